//--- src/mmio_map_pkg.sv
`default_nettype none

package mmio_map_pkg;

  localparam int unsigned word_w     = 32;
  localparam int unsigned num_lanes  = word_w / 8;
  localparam int unsigned addr_msb   = 30;  // Top bit of the core word address
  localparam int unsigned region_lsb = 12;  // 4 KB regions

  typedef logic [word_w-1:0]    word_t;
  typedef logic [num_lanes-1:0] byte_en_t;  // One strobe per byte lane
  typedef logic [1:0]           reg_idx_t;  // Address bits 3..2

  // Region code is address bits 30..12
  typedef enum logic [addr_msb-region_lsb:0] {
    region_ledsw = 19'd0,
    region_uart  = 19'd1,
    region_timer = 19'd2,
    region_none  = 19'd3  // Anything unmapped
  } region_e;

  // Byte-lane write merge
  function automatic word_t merge_lanes(word_t old_val, word_t new_val, byte_en_t be);
    word_t result;
    for (int i = 0; i < num_lanes; i++) begin
      result[8*i +: 8] = be[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
    end
    return result;
  endfunction

endpackage

`default_nettype wire

//--- src/periph_reg_pkg.sv
`default_nettype none

package periph_reg_pkg;

  // LED/switch region
  typedef enum logic [1:0] {
    ledsw_red    = 2'd0,
    ledsw_green  = 2'd1,
    ledsw_inputs = 2'd2  // Read only
  } ledsw_reg_e;

  localparam int unsigned led_r_w = 10;
  localparam int unsigned led_g_w = 8;
  localparam int unsigned sw_w    = 10;
  localparam int unsigned btn_w   = 4;
  localparam int unsigned btn_lsb = 16;  // Buttons sit in 19..16

  // UART region
  typedef enum logic [1:0] {
    uart_data   = 2'd0,
    uart_status = 2'd1
  } uart_reg_e;

  localparam int unsigned stat_tx_busy    = 0;
  localparam int unsigned stat_rx_valid   = 1;
  localparam int unsigned stat_rx_overrun = 2;

  // Timer region
  typedef enum logic [1:0] {
    timer_count   = 2'd0,
    timer_compare = 2'd1,
    timer_status  = 2'd2
  } timer_reg_e;

  localparam int unsigned stat_match = 0;

  // Shared by UART tx and rx FSMs
  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} uart_state_e;

endpackage

`default_nettype wire

//--- src/mmio_dev_if.sv
`default_nettype none

// One register window per peripheral
interface mmio_dev_if;
  import mmio_map_pkg::*;

  byte_en_t byte_en;  // Zero unless this region is addressed
  reg_idx_t reg_idx;
  word_t    wdata;
  word_t    rdata;    // Combinational from the device

  modport ctrl (
    output byte_en,
    output reg_idx,
    output wdata,
    input  rdata
  );

  modport dev (
    input  byte_en,
    input  reg_idx,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- src/mmio_decode.sv
`default_nettype none

module mmio_decode (
  input  logic [mmio_map_pkg::addr_msb:2] addr,
  input  mmio_map_pkg::byte_en_t          wren,
  input  mmio_map_pkg::word_t             data_in,
  output mmio_map_pkg::word_t             data_out,
  mmio_dev_if.ctrl                        ledsw_bus,
  mmio_dev_if.ctrl                        uart_bus,
  mmio_dev_if.ctrl                        timer_bus
);
  import mmio_map_pkg::*;

  region_e  region;
  reg_idx_t reg_idx;

  assign reg_idx = addr[3:2];  // Word select inside a region

  // 4 KB region lookup
  always_comb begin
    case (addr[addr_msb:region_lsb])
      region_ledsw: region = region_ledsw;
      region_uart:  region = region_uart;
      region_timer: region = region_timer;
      default:      region = region_none;
    endcase
  end

  // Strobes reach the addressed device only
  assign ledsw_bus.byte_en = (region == region_ledsw) ? wren : '0;
  assign uart_bus.byte_en  = (region == region_uart)  ? wren : '0;
  assign timer_bus.byte_en = (region == region_timer) ? wren : '0;

  // Index and data broadcast
  assign ledsw_bus.reg_idx = reg_idx;
  assign uart_bus.reg_idx  = reg_idx;
  assign timer_bus.reg_idx = reg_idx;
  assign ledsw_bus.wdata   = data_in;
  assign uart_bus.wdata    = data_in;
  assign timer_bus.wdata   = data_in;

  // Read return
  always_comb begin
    case (region)
      region_ledsw: data_out = ledsw_bus.rdata;
      region_uart:  data_out = uart_bus.rdata;
      region_timer: data_out = timer_bus.rdata;
      default:      data_out = '0;  // Unmapped reads zero
    endcase
  end

endmodule

`default_nettype wire

//--- src/mmio_ledsw.sv
`default_nettype none

module mmio_ledsw (
  input  logic                                clkrst_core_clk,
  input  logic                                arst_n,
  mmio_dev_if.dev                             bus,
  input  logic [periph_reg_pkg::sw_w-1:0]     ext_switches,
  input  logic [periph_reg_pkg::btn_w-1:0]    ext_buttons,
  output logic [periph_reg_pkg::led_r_w-1:0]  ext_led_r,
  output logic [periph_reg_pkg::led_g_w-1:0]  ext_led_g
);
  import mmio_map_pkg::*;
  import periph_reg_pkg::*;

  logic [sw_w-1:0]  sw_meta;
  logic [sw_w-1:0]  sw_sync;
  logic [btn_w-1:0] btn_meta;
  logic [btn_w-1:0] btn_sync;
  logic             wr;

  assign wr = |bus.byte_en;

  // LED registers, byte-lane writes
  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      ext_led_r <= '0;
      ext_led_g <= '0;
    end else if (wr) begin
      if (bus.reg_idx == ledsw_red)
        ext_led_r <= led_r_w'(merge_lanes(word_t'(ext_led_r), bus.wdata, bus.byte_en));
      if (bus.reg_idx == ledsw_green)
        ext_led_g <= led_g_w'(merge_lanes(word_t'(ext_led_g), bus.wdata, bus.byte_en));
    end
  end

  // Two-flop synchronizers for the board inputs
  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      sw_meta  <= '0;
      sw_sync  <= '0;
      btn_meta <= '0;
      btn_sync <= '0;
    end else begin
      sw_meta  <= ext_switches;
      sw_sync  <= sw_meta;
      btn_meta <= ext_buttons;
      btn_sync <= btn_meta;
    end
  end

  always_comb begin
    bus.rdata = '0;
    case (bus.reg_idx)
      ledsw_red:   bus.rdata = word_t'(ext_led_r);
      ledsw_green: bus.rdata = word_t'(ext_led_g);
      ledsw_inputs: begin
        bus.rdata[sw_w-1:0]         = sw_sync;
        bus.rdata[btn_lsb +: btn_w] = btn_sync;  // Buttons up in 19..16
      end
      default:     bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/mmio_uart.sv
`default_nettype none

module mmio_uart #(
  parameter int unsigned clks_per_bit = 16
) (
  input  logic    clkrst_core_clk,
  input  logic    arst_n,
  mmio_dev_if.dev bus,
  input  logic    ext_uart_rx,
  output logic    ext_uart_tx
);
  import mmio_map_pkg::*;
  import periph_reg_pkg::*;

  localparam int unsigned      cnt_w    = $clog2(clks_per_bit + 1);
  localparam logic [cnt_w-1:0] bit_max  = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] half_max = cnt_w'((clks_per_bit - 1) / 2);  // Mid-bit

  uart_state_e      tx_state;
  logic [cnt_w-1:0] tx_cnt;
  logic [2:0]       tx_bit_idx;
  logic [7:0]       tx_shift;
  logic             tx_tick;
  logic             tx_busy;
  logic             tx_wr;

  uart_state_e      rx_state;
  logic [cnt_w-1:0] rx_cnt;
  logic [2:0]       rx_bit_idx;
  logic [7:0]       rx_shift;
  logic [7:0]       rx_data;    // Holding register
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_tick;
  logic             rx_mid;
  logic             rx_done;
  logic             rx_valid;
  logic             rx_overrun;
  logic             stat_clr;

  assign tx_busy  = (tx_state != st_idle);
  assign tx_wr    = |bus.byte_en && (bus.reg_idx == uart_data);
  assign stat_clr = bus.byte_en[0] && (bus.reg_idx == uart_status);
  assign tx_tick  = (tx_cnt == bit_max);

  // Transmit FSM, line is registered
  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_state    <= st_idle;
      tx_cnt      <= '0;
      tx_bit_idx  <= '0;
      ext_uart_tx <= 1'b1;  // Idle high
    end else begin
      case (tx_state)
        st_idle: if (tx_wr) begin
          tx_state    <= st_start;
          ext_uart_tx <= 1'b0;
        end
        st_start: if (tx_tick) begin
          tx_state    <= st_data;
          tx_bit_idx  <= '0;
          ext_uart_tx <= tx_shift[0];  // LSB first
        end
        st_data: if (tx_tick) begin
          if (tx_bit_idx == 3'd7) begin
            tx_state    <= st_stop;
            ext_uart_tx <= 1'b1;
          end else begin
            tx_bit_idx  <= tx_bit_idx + 3'd1;
            ext_uart_tx <= tx_shift[tx_bit_idx + 3'd1];
          end
        end
        st_stop: if (tx_tick) tx_state <= st_idle;
        default: tx_state <= st_idle;
      endcase
      if (tx_state == st_idle || tx_tick) tx_cnt <= '0;
      else tx_cnt <= tx_cnt + 1'b1;
    end
  end

  assign rx_tick = (rx_cnt == bit_max);
  assign rx_mid  = (rx_state == st_start) && (rx_cnt == half_max);
  assign rx_done = (rx_state == st_stop) && rx_tick && rx_sync;  // Good stop bit only

  // Receive FSM, counter realigns at mid start bit
  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_meta    <= 1'b1;
      rx_sync    <= 1'b1;
      rx_state   <= st_idle;
      rx_cnt     <= '0;
      rx_bit_idx <= '0;
    end else begin
      rx_meta <= ext_uart_rx;
      rx_sync <= rx_meta;
      case (rx_state)
        st_idle:  if (!rx_sync) rx_state <= st_start;  // Falling edge
        st_start: if (rx_mid) begin
          rx_state   <= rx_sync ? st_idle : st_data;   // Glitch rejects
          rx_bit_idx <= '0;
        end
        st_data:  if (rx_tick) begin
          if (rx_bit_idx == 3'd7) rx_state <= st_stop;
          else rx_bit_idx <= rx_bit_idx + 3'd1;
        end
        st_stop:  if (rx_tick) rx_state <= st_idle;
        default:  rx_state <= st_idle;
      endcase
      if (rx_state == st_idle || rx_mid || rx_tick) rx_cnt <= '0;
      else rx_cnt <= rx_cnt + 1'b1;
    end
  end

  // Status flags, a new byte wins over a clear
  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_valid   <= 1'b0;
      rx_overrun <= 1'b0;
    end else begin
      if (stat_clr) begin
        rx_valid   <= 1'b0;
        rx_overrun <= 1'b0;
      end
      if (rx_done) begin
        rx_valid <= 1'b1;
        if (rx_valid) rx_overrun <= 1'b1;  // Unread byte lost
      end
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (tx_wr && !tx_busy) tx_shift <= bus.wdata[7:0];  // Busy writes dropped
    if (rx_state == st_data && rx_tick) rx_shift <= {rx_sync, rx_shift[7:1]};
    if (rx_done) rx_data <= rx_shift;
  end

  always_comb begin
    bus.rdata = '0;
    case (bus.reg_idx)
      uart_data: bus.rdata = word_t'(rx_data);
      uart_status: begin
        bus.rdata[stat_tx_busy]    = tx_busy;
        bus.rdata[stat_rx_valid]   = rx_valid;
        bus.rdata[stat_rx_overrun] = rx_overrun;
      end
      default:   bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/mmio_timer.sv
`default_nettype none

module mmio_timer (
  input  logic    clkrst_core_clk,
  input  logic    arst_n,
  mmio_dev_if.dev bus,
  output logic    timer_irq
);
  import mmio_map_pkg::*;
  import periph_reg_pkg::*;

  word_t count;
  word_t count_next;
  word_t compare;
  logic  match;
  logic  wr;

  assign wr = |bus.byte_en;

  // Load replaces the increment for that edge
  always_comb begin
    if (wr && bus.reg_idx == timer_count)
      count_next = merge_lanes(count, bus.wdata, bus.byte_en);
    else
      count_next = count + 32'd1;
  end

  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      count   <= '0;
      compare <= '0;
      match   <= 1'b0;
    end else begin
      count <= count_next;
      if (wr && bus.reg_idx == timer_compare)
        compare <= merge_lanes(compare, bus.wdata, bus.byte_en);
      if (bus.byte_en[0] && bus.reg_idx == timer_status) match <= 1'b0;
      if (count_next == compare) match <= 1'b1;  // Count steps onto compare
    end
  end

  assign timer_irq = match;  // Level until cleared

  always_comb begin
    bus.rdata = '0;
    case (bus.reg_idx)
      timer_count:   bus.rdata = count;
      timer_compare: bus.rdata = compare;
      timer_status:  bus.rdata[stat_match] = match;
      default:       bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/mcpu_soc_mmio.sv
`default_nettype none

module mcpu_soc_mmio #(
  parameter int unsigned clks_per_bit = 16  // UART bit period in core clocks
) (
  input  logic                                clkrst_core_clk,
  input  logic                                arst_n,
  input  logic [mmio_map_pkg::addr_msb:2]     addr,      // Word address
  input  mmio_map_pkg::word_t                 data_in,
  input  mmio_map_pkg::byte_en_t              wren,
  output mmio_map_pkg::word_t                 data_out,  // Combinational read
  output logic [periph_reg_pkg::led_r_w-1:0]  ext_led_r,
  output logic [periph_reg_pkg::led_g_w-1:0]  ext_led_g,
  input  logic [periph_reg_pkg::sw_w-1:0]     ext_switches,
  input  logic [periph_reg_pkg::btn_w-1:0]    ext_buttons,
  input  logic                                ext_uart_rx,
  output logic                                ext_uart_tx,
  output logic                                timer_irq
);

  mmio_dev_if ledsw_bus ();
  mmio_dev_if uart_bus ();
  mmio_dev_if timer_bus ();

  // Region decode and read mux
  mmio_decode u_decode (
    .addr      (addr),
    .wren      (wren),
    .data_in   (data_in),
    .data_out  (data_out),
    .ledsw_bus (ledsw_bus.ctrl),
    .uart_bus  (uart_bus.ctrl),
    .timer_bus (timer_bus.ctrl)
  );

  mmio_ledsw u_ledsw (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .bus             (ledsw_bus.dev),
    .ext_switches    (ext_switches),
    .ext_buttons     (ext_buttons),
    .ext_led_r       (ext_led_r),
    .ext_led_g       (ext_led_g)
  );

  mmio_uart #(
    .clks_per_bit (clks_per_bit)
  ) u_uart (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .bus             (uart_bus.dev),
    .ext_uart_rx     (ext_uart_rx),
    .ext_uart_tx     (ext_uart_tx)
  );

  mmio_timer u_timer (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .bus             (timer_bus.dev),
    .timer_irq       (timer_irq)
  );

endmodule

`default_nettype wire

//--- bench/tb_mcpu_soc_mmio.sv
`default_nettype none

module tb_mcpu_soc_mmio;
  import mmio_map_pkg::*;
  import periph_reg_pkg::*;

  // Four UART frames of 10 bits at 8 clocks, an idle wait of 100 and the
  // register traffic of the other tests come to well under 1000 cycles
  localparam int max_cycles = 2000;

  logic        clk = 1'b0;
  logic        arst_n;
  logic [30:2] addr;
  word_t       data_in;
  byte_en_t    wren;
  word_t       data_out;
  logic [9:0]  ext_led_r;
  logic [7:0]  ext_led_g;
  logic [9:0]  ext_switches;
  logic [3:0]  ext_buttons;
  wire         uart_line;  // tx looped back to rx
  logic        timer_irq;

  int          cycle_cnt = 0;
  int          errors = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  logic [9:0]  led_r_model;  // Expected LED state
  logic [7:0]  led_g_model;

  mcpu_soc_mmio #(
    .clks_per_bit (8)
  ) u_dut (
    .clkrst_core_clk (clk),
    .arst_n          (arst_n),
    .addr            (addr),
    .data_in         (data_in),
    .wren            (wren),
    .data_out        (data_out),
    .ext_led_r       (ext_led_r),
    .ext_led_g       (ext_led_g),
    .ext_switches    (ext_switches),
    .ext_buttons     (ext_buttons),
    .ext_uart_rx     (uart_line),
    .ext_uart_tx     (uart_line),
    .timer_irq       (timer_irq)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("Run stopped after %0d cycles without finishing", max_cycles);
      $display("sim failed");
      $finish;
    end
  end

  // Word address, region in 30..12 and register in 3..2
  function automatic logic [30:2] reg_addr(input logic [18:0] region, input logic [1:0] idx);
    return {region, 8'd0, idx};
  endfunction

  function automatic word_t lane_mask(input byte_en_t be);
    word_t m;
    m = '0;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) m[8*i +: 8] = 8'hff;
    end
    return m;
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Strobes held for one rising edge
  task automatic bus_write(input logic [30:2] a, input word_t d, input byte_en_t be);
    @(negedge clk);
    addr    = a;
    data_in = d;
    wren    = be;
    @(negedge clk);
    wren = '0;
  endtask

  task automatic bus_read(input logic [30:2] a, output word_t d);
    @(negedge clk);
    addr = a;
    wren = '0;
    #2;  // Mid low phase
    d = data_out;
  endtask

  task automatic bus_read_check(input logic [30:2] a, input word_t exp, input string name);
    word_t got;
    bus_read(a, got);
    check_value(name, got, exp);
  endtask

  task automatic reset_values();
    check_value("ext_led_r", word_t'(ext_led_r), '0);
    check_value("ext_led_g", word_t'(ext_led_g), '0);
    check_value("timer_irq", word_t'(timer_irq), '0);
    check_value("ext_uart_tx", word_t'(uart_line), 32'd1);  // Idle high
    bus_read_check(reg_addr(region_uart, uart_status), '0, "uart_status");
    bus_read_check(reg_addr(region_timer, timer_compare), '0, "timer_compare");
    bus_read_check(reg_addr(region_timer, timer_status), '0, "timer_status");
    bus_read_check(reg_addr(region_ledsw, ledsw_red), '0, "ledsw_red");
  endtask

  task automatic led_byte_lanes();
    word_t    rnd;
    word_t    wd;
    word_t    m;
    byte_en_t be;
    for (int i = 0; i < 6; i++) begin
      wd  = $urandom();
      rnd = $urandom();
      be  = rnd[3:0];
      m   = lane_mask(be);
      bus_write(reg_addr(region_ledsw, ledsw_red), wd, be);
      led_r_model = 10'((word_t'(led_r_model) & ~m) | (wd & m));
      bus_read_check(reg_addr(region_ledsw, ledsw_red), word_t'(led_r_model), "ledsw_red");
      check_value("ext_led_r", word_t'(ext_led_r), word_t'(led_r_model));
      be = rnd[7:4];  // Fresh lanes for green
      m  = lane_mask(be);
      bus_write(reg_addr(region_ledsw, ledsw_green), ~wd, be);
      led_g_model = 8'((word_t'(led_g_model) & ~m) | (~wd & m));
      bus_read_check(reg_addr(region_ledsw, ledsw_green), word_t'(led_g_model), "ledsw_green");
      check_value("ext_led_g", word_t'(ext_led_g), word_t'(led_g_model));
    end
    for (int i = 0; i < 3; i++) begin
      rnd = $urandom();
      @(negedge clk);
      ext_switches = rnd[9:0];
      ext_buttons  = rnd[13:10];
      repeat (2) @(negedge clk);  // Read lands on third edge
      bus_read_check(reg_addr(region_ledsw, ledsw_inputs),
                     {12'd0, rnd[13:10], 6'd0, rnd[9:0]}, "ledsw_inputs");
    end
  endtask

  task automatic decode_isolation();
    word_t       wd;
    word_t       rnd;
    logic [18:0] far_region;
    wd  = $urandom();
    rnd = $urandom();
    far_region = rnd[18:0] | 19'h40000;  // Always above region 2
    bus_write(reg_addr(region_ledsw, ledsw_red), wd, 4'hf);
    bus_write(reg_addr(region_ledsw, ledsw_green), wd, 4'hf);
    bus_write(reg_addr(region_ledsw, ledsw_inputs), ~wd, 4'hf);  // Read only
    led_r_model = wd[9:0];
    led_g_model = wd[7:0];
    bus_read_check(reg_addr(region_timer, timer_compare), '0, "timer_compare");
    // Unmapped writes go nowhere
    bus_write(reg_addr(19'd3, 2'd0), ~wd, 4'hf);
    bus_write(reg_addr(far_region, 2'd0), ~wd, 4'hf);
    check_value("ext_led_r", word_t'(ext_led_r), word_t'(led_r_model));
    check_value("ext_led_g", word_t'(ext_led_g), word_t'(led_g_model));
    bus_read_check(reg_addr(19'd3, 2'd0), '0, "data_out region 3");
    bus_read_check(reg_addr(19'd4, 2'd1), '0, "data_out region 4");
    bus_read_check(reg_addr(far_region, rnd[20:19]), '0, "data_out far region");
  endtask

  task automatic wait_tx_idle();
    word_t st;
    int    polls;
    polls = 0;
    st    = 32'd1;
    while (st[0] && polls < 400) begin
      bus_read(reg_addr(region_uart, uart_status), st);
      polls++;
    end
    if (st[0]) begin
      $display("UART transmitter still busy after %0d status reads", polls);
      errors++;
    end
  endtask

  task automatic uart_loopback();
    word_t      rnd;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    logic [7:0] b4;
    rnd = $urandom();
    b1  = rnd[7:0];
    b2  = rnd[15:8];
    b3  = rnd[23:16];
    b4  = rnd[31:24];
    // Single byte
    bus_write(reg_addr(region_uart, uart_data), word_t'(b1), 4'b0001);
    bus_read_check(reg_addr(region_uart, uart_status), 32'h1, "uart_status busy");
    wait_tx_idle();
    bus_read_check(reg_addr(region_uart, uart_status), 32'h2, "uart_status rx_valid");
    bus_read_check(reg_addr(region_uart, uart_data), word_t'(b1), "uart_data");
    bus_write(reg_addr(region_uart, uart_status), '0, 4'b0001);
    bus_read_check(reg_addr(region_uart, uart_status), '0, "uart_status cleared");
    // Two bytes, no clear between
    bus_write(reg_addr(region_uart, uart_data), word_t'(b2), 4'b0001);
    wait_tx_idle();
    bus_read_check(reg_addr(region_uart, uart_status), 32'h2, "uart_status first byte");
    bus_write(reg_addr(region_uart, uart_data), word_t'(b3), 4'b0001);
    wait_tx_idle();
    bus_read_check(reg_addr(region_uart, uart_status), 32'h6, "uart_status rx_overrun");
    bus_read_check(reg_addr(region_uart, uart_data), word_t'(b3), "uart_data overrun");
    bus_write(reg_addr(region_uart, uart_status), '0, 4'b0001);
    bus_read_check(reg_addr(region_uart, uart_status), '0, "uart_status cleared");
    // Second write lands while busy
    bus_write(reg_addr(region_uart, uart_data), word_t'(b4), 4'b0001);
    bus_read_check(reg_addr(region_uart, uart_status), 32'h1, "uart_status busy");
    bus_write(reg_addr(region_uart, uart_data), word_t'(~b4), 4'b0001);
    wait_tx_idle();
    repeat (100) @(negedge clk);  // Room for a frame that must not come
    bus_read_check(reg_addr(region_uart, uart_status), 32'h2, "uart_status one byte");
    bus_read_check(reg_addr(region_uart, uart_data), word_t'(b4), "uart_data first kept");
    bus_write(reg_addr(region_uart, uart_status), '0, 4'b0001);
  endtask

  task automatic timer_match();
    word_t rnd;
    word_t load_val;
    word_t now_val;
    word_t cmp_val;
    int    extra;
    int    waited;
    rnd      = $urandom();
    load_val = {2'b01, rnd[29:0]};  // Far from wrap and from compare zero
    rnd      = $urandom();
    extra    = int'(rnd[2:0]);
    bus_write(reg_addr(region_timer, timer_count), load_val, 4'hf);
    repeat (extra) @(negedge clk);  // One rising edge per wait
    bus_read_check(reg_addr(region_timer, timer_count), load_val + word_t'(extra) + 32'd1,
                   "timer_count");
    bus_read(reg_addr(region_timer, timer_count), now_val);
    cmp_val = now_val + 32'd20;
    bus_write(reg_addr(region_timer, timer_compare), cmp_val, 4'hf);
    check_value("timer_irq", word_t'(timer_irq), '0);
    bus_read_check(reg_addr(region_timer, timer_compare), cmp_val, "timer_compare");
    bus_read_check(reg_addr(region_timer, timer_status), '0, "timer_status early");
    waited = 0;
    while (!timer_irq && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (!timer_irq) begin
      $display("timer_irq did not rise within %0d cycles of the compare write", waited);
      errors++;
    end else begin
      bus_read_check(reg_addr(region_timer, timer_count), cmp_val + 32'd1, "timer_count match");
      bus_read_check(reg_addr(region_timer, timer_status), 32'h1, "timer_status match");
      bus_write(reg_addr(region_timer, timer_status), '0, 4'b1110);  // Lane 0 off keeps it
      bus_read_check(reg_addr(region_timer, timer_status), 32'h1, "timer_status kept");
      bus_write(reg_addr(region_timer, timer_status), '0, 4'b0001);
      bus_read_check(reg_addr(region_timer, timer_status), '0, "timer_status cleared");
      check_value("timer_irq", word_t'(timer_irq), '0);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d check(s) failed", name, errors - errors_before);
      tests_bad++;
    end
  endtask

  initial begin
    int seed_ret;
    int e0;
    seed_ret     = $urandom(32'h4d471978);
    arst_n       = 1'b0;
    addr         = '0;
    data_in      = '0;
    wren         = '0;
    ext_switches = '0;
    ext_buttons  = '0;
    led_r_model  = '0;
    led_g_model  = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    e0 = errors;
    reset_values();
    report_test("reset values", e0);
    e0 = errors;
    led_byte_lanes();
    report_test("led byte lanes", e0);
    e0 = errors;
    decode_isolation();
    report_test("decode isolation", e0);
    e0 = errors;
    uart_loopback();
    report_test("uart loopback", e0);
    e0 = errors;
    timer_match();
    report_test("timer match", e0);

    $display("tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mcpu_soc_mmio.f
src/mmio_map_pkg.sv
src/periph_reg_pkg.sv
src/mmio_dev_if.sv
src/mmio_decode.sv
src/mmio_ledsw.sv
src/mmio_uart.sv
src/mmio_timer.sv
src/mcpu_soc_mmio.sv
bench/tb_mcpu_soc_mmio.sv
